//--- verilog/uart_loader_pkg.sv
package uart_loader_pkg;

    // serial timing, in clocks
    localparam int bps_cnt = 16;
    // sample point inside a bit period
    localparam int half_bps = 8;

    // loading ends after this many words
    localparam int max_words = 8;
    // or after this many quiet bit times once a byte was seen
    localparam int max_idle_bits = 40;

    localparam int data_w = 32;

    // one received byte, valid for a single cycle
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

    // one word write towards memory
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] addr;
        logic [data_w-1:0] data;
    } mem_write_t;

endpackage

//--- verilog/uart_rx_framer.sv
module uart_rx_framer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rx,
    output uart_loader_pkg::rx_byte_t byte_out,
    output logic                      line_active
);

    logic [2:0] rx_sync;
    logic       fall;
    logic       busy;
    logic       stop_tail;
    logic       mid_bit;
    logic       bit_end;
    logic       byte_valid;
    logic [3:0] bit_cnt;
    logic [7:0] shift;
    logic [$clog2(uart_loader_pkg::bps_cnt)-1:0] baud_cnt;

    // rx_sync[0] takes the raw line
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= '1;
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
        end
    end

    assign fall    = rx_sync[2] & ~rx_sync[1];
    assign mid_bit = (baud_cnt == uart_loader_pkg::half_bps - 1);
    assign bit_end = (baud_cnt == uart_loader_pkg::bps_cnt - 1);

    // bit 0 is start, 1..8 data, 9 stop
    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            stop_tail  <= 1'b0;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (!busy && fall) begin
                busy      <= 1'b1;
                stop_tail <= 1'b0;
                baud_cnt  <= '0;
                bit_cnt   <= '0;
            end else if (busy) begin
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (mid_bit) begin
                    if (bit_cnt == 4'd0 && rx_sync[1]) begin
                        // start bit gone by mid-bit, just noise
                        busy <= 1'b0;
                    end else if (bit_cnt == 4'd9) begin
                        busy       <= 1'b0;
                        stop_tail  <= 1'b1;
                        byte_valid <= rx_sync[1];
                    end
                end
            end else if (stop_tail) begin
                // second half of the stop bit
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                if (bit_end) begin
                    stop_tail <= 1'b0;
                end
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (busy && mid_bit && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shift <= {rx_sync[1], shift[7:1]};
        end
    end

    always_comb begin
        byte_out.valid = byte_valid;
        byte_out.data  = shift;
    end

    assign line_active = busy | stop_tail;

    strobe_single_cycle: assert property (
        @(posedge clk) disable iff (rst) byte_valid |=> !byte_valid
    );

endmodule

//--- verilog/word_assembler.sv
module word_assembler (
    input  logic                        clk,
    input  logic                        rst,
    input  uart_loader_pkg::rx_byte_t   byte_in,
    output uart_loader_pkg::mem_write_t mem_write
);

    logic [1:0]                        lane;
    logic                              wr_valid;
    logic [uart_loader_pkg::data_w-1:0] word;
    logic [uart_loader_pkg::data_w-1:0] addr;

    // lane 3 completes a word
    always_ff @(posedge clk) begin
        if (rst) begin
            lane     <= '0;
            wr_valid <= 1'b0;
            addr     <= '0;
        end else begin
            wr_valid <= byte_in.valid && (lane == 2'd3);
            if (byte_in.valid) begin
                lane <= lane + 1'b1;
            end
            // address moves on once the write has gone out
            if (wr_valid) begin
                addr <= addr + 3'd4;
            end
        end
    end

    // newest byte enters at the top, first byte ends up in [7:0]
    always_ff @(posedge clk) begin
        if (byte_in.valid) begin
            word <= {byte_in.data, word[uart_loader_pkg::data_w-1:8]};
        end
    end

    always_comb begin
        mem_write.valid = wr_valid;
        mem_write.addr  = addr;
        mem_write.data  = word;
    end

    addr_word_aligned: assert property (
        @(posedge clk) disable iff (rst) addr[1:0] == 2'b00
    );

endmodule

//--- verilog/load_monitor.sv
module load_monitor (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        byte_seen,
    input  logic                        line_active,
    input  uart_loader_pkg::mem_write_t mem_write,
    output logic                        done
);

    logic received;
    logic [$clog2(uart_loader_pkg::max_words+1)-1:0]     word_cnt;
    logic [$clog2(uart_loader_pkg::bps_cnt)-1:0]         bit_div;
    logic [$clog2(uart_loader_pkg::max_idle_bits+1)-1:0] idle_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt <= '0;
        end else if (mem_write.valid && word_cnt != uart_loader_pkg::max_words) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // idle time only counts once something has been received
    always_ff @(posedge clk) begin
        if (rst) begin
            received <= 1'b0;
            bit_div  <= '0;
            idle_cnt <= '0;
        end else begin
            if (byte_seen) begin
                received <= 1'b1;
            end
            if (line_active || !received) begin
                bit_div  <= '0;
                idle_cnt <= '0;
            end else if (idle_cnt != uart_loader_pkg::max_idle_bits) begin
                if (bit_div == uart_loader_pkg::bps_cnt - 1) begin
                    bit_div  <= '0;
                    idle_cnt <= idle_cnt + 1'b1;
                end else begin
                    bit_div <= bit_div + 1'b1;
                end
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (mem_write.valid && word_cnt == uart_loader_pkg::max_words - 1) begin
            done <= 1'b1;
        end else if (idle_cnt == uart_loader_pkg::max_idle_bits) begin
            done <= 1'b1;
        end
    end

    no_write_after_done: assert property (
        @(posedge clk) disable iff (rst) done |-> !mem_write.valid
    );

    // assembler address tracks the words counted here
    write_addr_in_order: assert property (
        @(posedge clk) disable iff (rst)
        mem_write.valid |-> mem_write.addr == {word_cnt, 2'b00}
    );

endmodule

//--- verilog/uart_loader_top.sv
module uart_loader_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rx,
    output uart_loader_pkg::mem_write_t mem_write,
    output logic                        done
);

    uart_loader_pkg::rx_byte_t byte_strb;
    logic                      line_active;

    uart_rx_framer uart_rx_framer_inst (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .byte_out    (byte_strb),
        .line_active (line_active)
    );

    word_assembler word_assembler_inst (
        .clk       (clk),
        .rst       (rst),
        .byte_in   (byte_strb),
        .mem_write (mem_write)
    );

    load_monitor load_monitor_inst (
        .clk         (clk),
        .rst         (rst),
        .byte_seen   (byte_strb.valid),
        .line_active (line_active),
        .mem_write   (mem_write),
        .done        (done)
    );

endmodule

//--- sim/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int half_period = 4;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // power-on reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- sim/tb_checker.sv
module tb_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        sent_valid,
    input  logic [7:0]                  sent_byte,
    input  uart_loader_pkg::mem_write_t mem_write,
    input  logic                        done,
    output int                          error_count,
    output int                          words_pending
);

    logic [7:0] sent[$];
    longint     due[$];
    longint     cycle;
    longint     last_frame_end;
    longint     full_at;
    int         word_idx;
    logic       have_byte;
    logic       done_prev;
    logic       late_reported;

    // sent bytes packed lsb first, word n lives at address 4*n
    function automatic uart_loader_pkg::mem_write_t expected_write(input int idx);
        uart_loader_pkg::mem_write_t w;
        w.valid = 1'b1;
        w.addr  = 32'(idx * 4);
        w.data  = {sent[4*idx+3], sent[4*idx+2], sent[4*idx+1], sent[4*idx]};
        return w;
    endfunction

    task automatic check_write;
        uart_loader_pkg::mem_write_t exp;
        if (word_idx >= uart_loader_pkg::max_words || 4 * word_idx + 4 > sent.size()) begin
            $display("unexpected word write at %0t to address %h", $time, mem_write.addr);
            error_count++;
        end else begin
            exp = expected_write(word_idx);
            if (mem_write.addr !== exp.addr || mem_write.data !== exp.data) begin
                $display("mismatch at %0t: word %0d got addr %h data %h, expected addr %h data %h",
                         $time, word_idx, mem_write.addr, mem_write.data, exp.addr, exp.data);
                error_count++;
            end
            if (due.size() > 0) begin
                due.pop_front();
            end
        end
        word_idx++;
        if (word_idx == uart_loader_pkg::max_words) begin
            full_at = cycle;
        end
    endtask

    task automatic check_done;
        longint quiet;
        quiet = cycle - last_frame_end;
        if (done && !done_prev) begin
            if (!have_byte) begin
                $display("done rose at %0t before any byte was sent", $time);
                error_count++;
            end else if (word_idx < uart_loader_pkg::max_words &&
                         quiet < uart_loader_pkg::max_idle_bits * uart_loader_pkg::bps_cnt) begin
                $display("done rose too early at %0t, %0d words and %0d quiet cycles",
                         $time, word_idx, quiet);
                error_count++;
            end
        end
        if (!done && done_prev) begin
            $display("done fell at %0t without a reset", $time);
            error_count++;
        end
        if (!done && !late_reported) begin
            if (full_at >= 0 && cycle > full_at) begin
                $display("done still low at %0t after the last word write", $time);
                error_count++;
                late_reported = 1'b1;
            end else if (have_byte && quiet >
                         (uart_loader_pkg::max_idle_bits + 1) * uart_loader_pkg::bps_cnt) begin
                $display("done still low at %0t after %0d quiet cycles", $time, quiet);
                error_count++;
                late_reported = 1'b1;
            end
        end
    endtask

    initial begin
        error_count    = 0;
        words_pending  = 0;
        cycle          = 0;
        last_frame_end = 0;
        full_at        = -1;
        word_idx       = 0;
        have_byte      = 1'b0;
        done_prev      = 1'b0;
        late_reported  = 1'b0;
    end

    always @(posedge clk) begin
        cycle++;
        if (rst) begin
            sent.delete();
            due.delete();
            word_idx      = 0;
            full_at       = -1;
            have_byte     = 1'b0;
            done_prev     = 1'b0;
            late_reported = 1'b0;
        end else begin
            if (sent_valid) begin
                sent.push_back(sent_byte);
                have_byte      = 1'b1;
                last_frame_end = cycle + 10 * uart_loader_pkg::bps_cnt;
                // a finished group must be written before the frame is well over
                if (sent.size() % 4 == 0 && sent.size() / 4 <= uart_loader_pkg::max_words) begin
                    due.push_back(cycle + 11 * uart_loader_pkg::bps_cnt);
                end
            end
            if (mem_write.valid) begin
                check_write();
            end
            if (due.size() > 0 && cycle > due[0]) begin
                $display("word %0d was never written, deadline passed at %0t", word_idx, $time);
                error_count++;
                due.pop_front();
                word_idx++;
            end
            check_done();
            done_prev = done;
        end
        words_pending = due.size();
    end

endmodule

//--- sim/tb_uart_loader.sv
module tb_uart_loader;

    localparam int clk_period = 8;
    localparam int gap_clks   = 3;
    // frames and idle bit times over all tests
    localparam int frame_total = 8 + 33 + 6 + 4;
    localparam int idle_bits   = 4 + 2 + uart_loader_pkg::max_idle_bits + 1 + 1 + 2;
    localparam int margin_bits = 60;
    localparam longint watchdog_time = longint'(frame_total * 10 + idle_bits + margin_bits)
                                       * uart_loader_pkg::bps_cnt * clk_period;

    logic                        clk;
    logic                        por_rst;
    logic                        run_rst;
    logic                        dut_rst;
    logic                        rx;
    logic                        sent_valid;
    logic [7:0]                  sent_byte;
    logic [15:0]                 lfsr;
    int                          tb_errors;
    int                          checker_errors;
    int                          words_pending;
    uart_loader_pkg::mem_write_t mem_write;
    logic                        done;

    assign dut_rst = por_rst | run_rst;

    tb_clock tb_clock_inst (
        .clk (clk),
        .rst (por_rst)
    );

    uart_loader_top uart_loader_top_inst (
        .clk       (clk),
        .rst       (dut_rst),
        .rx        (rx),
        .mem_write (mem_write),
        .done      (done)
    );

    tb_checker tb_checker_inst (
        .clk           (clk),
        .rst           (dut_rst),
        .sent_valid    (sent_valid),
        .sent_byte     (sent_byte),
        .mem_write     (mem_write),
        .done          (done),
        .error_count   (checker_errors),
        .words_pending (words_pending)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    // start bit, 8 data bits lsb first, stop bit, then a short gap
    task automatic send_frame(input logic [7:0] b);
        @(negedge clk);
        rx         = 1'b0;
        sent_byte  = b;
        sent_valid = 1'b1;
        @(negedge clk);
        sent_valid = 1'b0;
        repeat (uart_loader_pkg::bps_cnt - 1) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (uart_loader_pkg::bps_cnt) @(negedge clk);
        end
        rx = 1'b1;
        repeat (uart_loader_pkg::bps_cnt + gap_clks) @(negedge clk);
    endtask

    task automatic send_random_bytes(input int n);
        logic [7:0] b;
        repeat (n) begin
            random_byte(b);
            send_frame(b);
        end
    endtask

    task automatic send_glitch(input int low_clks);
        @(negedge clk);
        rx = 1'b0;
        repeat (low_clks) @(negedge clk);
        rx = 1'b1;
        repeat (uart_loader_pkg::bps_cnt) @(negedge clk);
    endtask

    task automatic pulse_reset;
        @(negedge clk);
        run_rst = 1'b1;
        repeat (4) @(negedge clk);
        run_rst = 1'b0;
    endtask

    task automatic wait_for_writes;
        int n;
        n = 0;
        while (words_pending != 0 && n < 12 * uart_loader_pkg::bps_cnt) begin
            @(negedge clk);
            n++;
        end
        if (words_pending != 0) begin
            $display("timed out at %0t with %0d word writes outstanding", $time, words_pending);
            tb_errors++;
        end
    endtask

    task automatic wait_for_done(input int max_clks);
        int n;
        n = 0;
        while (!done && n < max_clks) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("done did not rise within %0d cycles, at %0t", max_clks, $time);
            tb_errors++;
        end
    endtask

    initial begin
        #(watchdog_time);
        $display("watchdog expired at %0t before the tests finished", $time);
        $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rx         = 1'b1;
        run_rst    = 1'b0;
        sent_valid = 1'b0;
        sent_byte  = '0;
        lfsr       = 16'd15;
        tb_errors  = 0;
        wait (por_rst == 1'b0);
        @(negedge clk);

        // quiet line after reset
        repeat (4 * uart_loader_pkg::bps_cnt) @(negedge clk);

        send_random_bytes(8);
        wait_for_writes();
        pulse_reset();

        // full load, then one byte too many
        send_random_bytes(32);
        wait_for_writes();
        wait_for_done(4);
        send_random_bytes(1);
        repeat (2 * uart_loader_pkg::bps_cnt) @(negedge clk);
        pulse_reset();

        // partial load ended by the idle timeout
        send_random_bytes(6);
        wait_for_writes();
        wait_for_done((uart_loader_pkg::max_idle_bits + 1) * uart_loader_pkg::bps_cnt);
        pulse_reset();

        send_random_bytes(2);
        send_glitch(uart_loader_pkg::half_bps - 3);
        send_random_bytes(2);
        wait_for_writes();
        repeat (2 * uart_loader_pkg::bps_cnt) @(negedge clk);

        $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/uart_loader_pkg.sv
verilog/uart_rx_framer.sv
verilog/word_assembler.sv
verilog/load_monitor.sv
verilog/uart_loader_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_uart_loader.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_uart_loader -Mdir obj_dir -o tb_uart_loader > build.log 2>&1 \
    && ./obj_dir/tb_uart_loader > sim.log 2>&1 \
    || { echo "build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "TB PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
